/* bench/platformerTb.sv */
/*
 * Self-checking testbench for the platformer core with short dividers.
 * A cycle model tracks position, velocity and the two stage colour pipe.
 * Walking is steered toward moving goal positions so that edges and
 * platforms are reached within the fixed run length.
 */
module platformerTb
    import platformerPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MOVE_DIV       = 4;
    localparam int GRAV_DIV       = 8;
    localparam int RUN_CYCLES     = 40000;
    localparam int IDLE_CYCLES    = 40;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 8;
    localparam int BOX_W          = int'(CHAR_WIDTH);
    localparam int BOX_H          = int'(CHAR_HEIGHT);
    localparam int LEFT_LIM       = int'(SCREEN_LEFT);
    localparam int RIGHT_LIM      = int'(SCREEN_RIGHT);
    localparam int GROUND_TOP     = int'(GROUND_Y);
    localparam int TILE           = int'(TILE_SIZE);

    logic  clk;
    logic  rst;
    logic  bright;
    logic  btnLeft;
    logic  btnRight;
    logic  btnJump;
    coordT hCount;
    coordT vCount;
    rgbT   rgb;
    coordT playerX;
    coordT playerY;

    // model state
    int   mX;
    int   mY;
    int   mVel;
    logic mAir;
    logic mLedge;
    int   mMoveCnt;
    int   mGravCnt;
    logic stBright;
    logic stPlayer;
    logic stGround;
    logic stPlat;
    rgbT  mRgb;

    int seed = 90;
    int spanLeft;
    int goal;
    int cycleCount = 0;
    // behaviour counters
    int jumps;
    int headbutts;
    int groundLandings;
    int platformLandings;
    int ledgeFalls;
    int ledgeGroundLandings;
    int leftEdgeStops;
    int rightEdgeStops;
    int platformStops [NUM_PLATFORMS];
    int leftWins;

    platformerTop #(
        .MOVE_DIV (MOVE_DIV),
        .GRAV_DIV (GRAV_DIV)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .bright   (bright),
        .btnLeft  (btnLeft),
        .btnRight (btnRight),
        .btnJump  (btnJump),
        .hCount   (hCount),
        .vCount   (vCount),
        .rgb      (rgb),
        .playerX  (playerX),
        .playerY  (playerY)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////
    // collision model
    ////////////////////////////////////////
    function automatic logic spansColumn(int x, int i);
        int px;
        px = int'(PLATFORM_X[i]);
        return x < px + TILE && x + BOX_W > px;
    endfunction

    // index of a platform the box overlaps, -1 for none
    function automatic int blockingPlatform(int x, int y);
        int hit;
        int py;
        hit = -1;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            py = int'(PLATFORM_Y[i]);
            if (spansColumn(x, i) && y < py + TILE && y + BOX_H > py)
                hit = i;
        end
        return hit;
    endfunction

    // top strictly inside with bottom edge counted
    function automatic logic headInPlatform(int x, int y);
        logic hit;
        int   py;
        hit = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            py = int'(PLATFORM_Y[i]);
            if (spansColumn(x, i) && y > py && y <= py + TILE)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // snap target or -1 when nothing holds the feet
    function automatic int landingTop(int x, int y);
        int feet;
        int top;
        int py;
        feet = y + BOX_H;
        top = -1;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            py = int'(PLATFORM_Y[i]);
            if (spansColumn(x, i) && feet >= py && feet <= py + int'(LAND_TOL))
                top = py - BOX_H;
        end
        if (feet >= GROUND_TOP)
            top = GROUND_TOP - BOX_H;
        return top;
    endfunction

    function automatic logic scanOnPlatform(int h, int v);
        logic hit;
        int   px;
        int   py;
        hit = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            px = int'(PLATFORM_X[i]);
            py = int'(PLATFORM_Y[i]);
            if (h >= px && h < px + TILE && v >= py && v < py + TILE)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // every required behaviour seen at least once
    function automatic logic allBehavioursSeen();
        logic seen;
        seen = jumps > 0 && headbutts > 0 && groundLandings > 0 && platformLandings > 0 &&
               ledgeFalls > 0 && ledgeGroundLandings > 0 && leftWins > 0 &&
               leftEdgeStops > 0 && rightEdgeStops > 0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (platformStops[i] == 0)
                seen = 1'b0;
        end
        return seen;
    endfunction

    ////////////////////////////////////////
    // cycle model for one rising edge
    ////////////////////////////////////////
    task automatic stepModel();
        int   land;
        int   nx;
        int   h;
        int   v;
        int   blocker;
        logic moveTick;
        logic gravTick;
        land = landingTop(mX, mY);
        h = int'(hCount);
        v = int'(vCount);
        moveTick = (btnLeft || btnRight) && mMoveCnt == MOVE_DIV - 1;
        gravTick = mGravCnt == GRAV_DIV - 1;
        // colour from last flags before new flags
        if (!stBright)
            mRgb = BLACK;
        else if (stPlayer)
            mRgb = PLAYER_COLOR;
        else if (stGround)
            mRgb = GROUND_COLOR;
        else if (stPlat)
            mRgb = PLATFORM_COLOR;
        else
            mRgb = SKY_COLOR;
        stBright = bright;
        stPlayer = h >= mX && h < mX + BOX_W && v >= mY && v < mY + BOX_H;
        stGround = v >= GROUND_TOP + BOX_H && v <= int'(GROUND_BOTTOM);
        stPlat = scanOnPlatform(h, v);
        // walking with left first
        nx = mX;
        if (moveTick && btnLeft) begin
            if (btnRight)
                leftWins++;
            blocker = blockingPlatform(mX - 1, mY);
            if (mX > LEFT_LIM && blocker < 0)
                nx = mX - 1;
            else if (mX == LEFT_LIM)
                leftEdgeStops++;
            else
                platformStops[blocker]++;
        end else if (moveTick) begin
            blocker = blockingPlatform(mX + 1, mY);
            if (mX < RIGHT_LIM && blocker < 0)
                nx = mX + 1;
            else if (mX == RIGHT_LIM)
                rightEdgeStops++;
            else
                platformStops[blocker]++;
        end
        mMoveCnt = (!(btnLeft || btnRight) || moveTick) ? 0 : mMoveCnt + 1;
        mGravCnt = gravTick ? 0 : mGravCnt + 1;
        // vertical
        if (!mAir) begin
            if (btnJump && land >= 0) begin
                mAir = 1'b1;
                mVel = -int'(JUMP_VEL);
                jumps++;
            end else if (land < 0) begin
                mAir = 1'b1;
                mLedge = 1'b1;
                mVel = 1;
                ledgeFalls++;
            end
        end else if (gravTick) begin
            if (mVel < 0 && headInPlatform(mX, mY)) begin
                mVel = 0;
                headbutts++;
            end else if (mVel > 0 && land >= 0) begin
                mY = land;
                mVel = 0;
                mAir = 1'b0;
                if (land == GROUND_TOP - BOX_H) begin
                    groundLandings++;
                    if (mLedge)
                        ledgeGroundLandings++;
                end else begin
                    platformLandings++;
                end
                mLedge = 1'b0;
            end else begin
                mY = mY + mVel;
                mVel = mVel + int'(GRAVITY);
            end
        end
        mX = nx;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic driveInputs(logic useButtons);
        int pick;
        int idx;
        int h;
        int v;
        if (useButtons && spanLeft == 0) begin
            spanLeft = 1 + {$random(seed)} % 64;
            pick = {$random(seed)} % 8;
            btnJump = ({$random(seed)} % 2) == 1;
            // 1 holds both and 2 and up head for the goal
            btnLeft = pick == 1 || (pick >= 2 && goal < mX);
            btnRight = pick == 1 || (pick >= 2 && goal > mX);
        end
        if (useButtons)
            spanLeft--;
        pick = {$random(seed)} % 8;
        idx = {$random(seed)} % NUM_PLATFORMS;
        h = {$random(seed)} % 1024;
        v = {$random(seed)} % 1024;
        if (pick == 4 || pick == 7) begin
            h = mX - 8 + h % 48;
            v = mY - 8 + v % 48;
        end else if (pick == 5) begin
            h = int'(PLATFORM_X[idx]) - 4 + h % 32;
            v = int'(PLATFORM_Y[idx]) - 4 + v % 32;
        end else if (pick == 6) begin
            // straddles the ground band
            v = GROUND_TOP + 20 + v % 48;
        end
        hCount = coordT'(h);
        vCount = coordT'(v);
        bright = ({$random(seed)} % 4) != 0;
    endtask

    initial begin
        rst = 1'b1;
        bright = 1'b0;
        btnLeft = 1'b0;
        btnRight = 1'b0;
        btnJump = 1'b0;
        hCount = '0;
        vCount = '0;
        spanLeft = 0;
        goal = START_X;
        mX = int'(START_X);
        mY = GROUND_TOP - BOX_H;
        mVel = 0;
        mAir = 1'b0;
        mLedge = 1'b0;
        mMoveCnt = 0;
        mGravCnt = 0;
        stBright = 1'b0;
        stPlayer = 1'b0;
        stGround = 1'b0;
        stPlat = 1'b0;
        mRgb = BLACK;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        checkValue("playerX", 32'(playerX), 32'(START_X));
        checkValue("playerY", 32'(playerY), 32'(GROUND_TOP - BOX_H));
        checkValue("rgb", 32'(rgb), 32'(BLACK));
        for (int c = 0; c < RUN_CYCLES; c++) begin
            // goals at both edges and then near the platforms
            if (c < 7000)
                goal = 0;
            else if (c < 17000)
                goal = 1023;
            else if (c < 24000)
                goal = 480;
            else if (c < 32000)
                goal = 240;
            else
                goal = 600;
            driveInputs(c >= IDLE_CYCLES);
            @(posedge clk);
            #1;
            stepModel();
            checkValue("playerX", 32'(playerX), 32'(mX));
            checkValue("playerY", 32'(playerY), 32'(mY));
            checkValue("rgb", 32'(rgb), 32'(mRgb));
            if (c < IDLE_CYCLES) begin
                checkValue("playerX", 32'(playerX), 32'(START_X));
                checkValue("playerY", 32'(playerY), 32'(GROUND_TOP - BOX_H));
            end
            #1;
        end
        $display("jumps %0d headbutts %0d ground %0d platform %0d ledge %0d",
                 jumps, headbutts, groundLandings, platformLandings, ledgeFalls);
        $display("ledge to ground %0d left wins %0d", ledgeGroundLandings, leftWins);
        $display("edge stops left %0d right %0d", leftEdgeStops, rightEdgeStops);
        for (int i = 0; i < NUM_PLATFORMS; i++)
            $display("stops at platform x %0d: %0d", PLATFORM_X[i], platformStops[i]);
        if (!allBehavioursSeen()) begin
            $display("a required behaviour was never exercised");
            $display("TEST RESULT: FAIL");
            $fatal(1, "coverage incomplete");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* bench/platformer_checker.sv */
/*
 * Motion invariants for playerMotion, attached by bind.
 * Checked on the rising clock edge and ignored while rst is high.
 */
module platformerChecker
    import platformerPkg::*;
(
    input logic        clk,
    input logic        rst,
    input motionStateT state,
    input velT         velY,
    input coordT       posX,
    input coordT       posY,
    input logic        gravTick
);
    timeunit 1ns;
    timeprecision 100ps;

    // standing player carries no speed
    groundedStill: assert property (@(posedge clk) disable iff (rst)
        state == GROUNDED |-> velY == '0)
        else $error("velocity %0d while grounded", velY);

    // edge limits of the left box edge
    xOnScreen: assert property (@(posedge clk) disable iff (rst)
        posX >= SCREEN_LEFT && posX <= SCREEN_RIGHT)
        else $error("x %0d outside the screen limits", posX);

    // landing snap also falls on a physics tick
    yOnTick: assert property (@(posedge clk) disable iff (rst)
        !gravTick |=> $stable(posY))
        else $error("y changed outside a physics tick");

endmodule

bind playerMotion platformerChecker checker0 (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .velY     (velY),
    .posX     (posX),
    .posY     (posY),
    .gravTick (gravTick)
);

/* rtl/collisionIf.sv */
/*
 * Collision query bundle between the motion unit and the platform map.
 * All answers are combinational and refer to the current position.
 */
interface collisionIf
    import platformerPkg::*;
();

    // probe position, top-left of the player box
    coordT posX;
    coordT posY;

    // map answers
    logic  blockedLeft;
    logic  blockedRight;
    logic  headbutt;
    logic  supported;
    coordT landY;

    modport motion (output posX, posY, input blockedLeft, blockedRight, headbutt, supported, landY);
    modport map (input posX, posY, output blockedLeft, blockedRight, headbutt, supported, landY);

endinterface

/* rtl/pixelRenderer.sv */
/*
 * Two stage pixel colouring from the scan position.
 * rgb follows hCount, vCount and bright by two clocks.
 * Priority is blank, player, ground, platform, sky.
 */
module pixelRenderer
    import platformerPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  bright,
    input  coordT hCount,
    input  coordT vCount,
    input  coordT playerX,
    input  coordT playerY,
    output rgbT   rgb
);

    logic inPlayer;
    logic inGround;
    logic inPlatform;
    logic brightQ;
    logic inPlayerQ;
    logic inGroundQ;
    logic inPlatformQ;

    assign inPlayer = (hCount >= playerX) && (hCount < playerX + CHAR_WIDTH) &&
                      (vCount >= playerY) && (vCount < playerY + CHAR_HEIGHT);

    // ground band below the walking surface
    assign inGround = (vCount >= GROUND_Y + CHAR_HEIGHT) && (vCount <= GROUND_BOTTOM);

    always_comb begin
        inPlatform = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (hCount >= PLATFORM_X[i] && hCount < PLATFORM_X[i] + TILE_SIZE &&
                vCount >= PLATFORM_Y[i] && vCount < PLATFORM_Y[i] + TILE_SIZE)
                inPlatform = 1'b1;
        end
    end

    // stage one, flags; stage two, colour
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            brightQ     <= 1'b0;
            inPlayerQ   <= 1'b0;
            inGroundQ   <= 1'b0;
            inPlatformQ <= 1'b0;
            rgb         <= BLACK;
        end else begin
            brightQ     <= bright;
            inPlayerQ   <= inPlayer;
            inGroundQ   <= inGround;
            inPlatformQ <= inPlatform;
            if (!brightQ)
                rgb <= BLACK;
            else if (inPlayerQ)
                rgb <= PLAYER_COLOR;
            else if (inGroundQ)
                rgb <= GROUND_COLOR;
            else if (inPlatformQ)
                rgb <= PLATFORM_COLOR;
            else
                rgb <= SKY_COLOR;
        end
    end

endmodule

/* rtl/platformMap.sv */
/*
 * Purely combinational platform collision queries.
 * Screen edge limits are not handled here. If two platforms would
 * both hold the player, the later table entry gives landY.
 */
module platformMap
    import platformerPkg::*;
(
    collisionIf.map bus
);

    coordT feet;
    logic  hitLeft;
    logic  hitRight;
    logic  hitHead;
    logic  onPlatform;
    logic  onGround;
    coordT platTop;

    // horizontal overlap of a box at x with platform i
    function automatic logic overlapsX(coordT x, int i);
        return (x + CHAR_WIDTH > PLATFORM_X[i]) && (x < PLATFORM_X[i] + TILE_SIZE);
    endfunction

    // full box overlap for the side probes
    function automatic logic overlapsBox(coordT x, coordT y, int i);
        return overlapsX(x, i) &&
               (y + CHAR_HEIGHT > PLATFORM_Y[i]) && (y < PLATFORM_Y[i] + TILE_SIZE);
    endfunction

    assign feet = bus.posY + CHAR_HEIGHT;

    always_comb begin
        hitLeft    = 1'b0;
        hitRight   = 1'b0;
        hitHead    = 1'b0;
        onPlatform = 1'b0;
        platTop    = GROUND_Y - CHAR_HEIGHT;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            // one pixel step either way
            if (overlapsBox(bus.posX - 10'd1, bus.posY, i))
                hitLeft = 1'b1;
            if (overlapsBox(bus.posX + 10'd1, bus.posY, i))
                hitRight = 1'b1;
            // top edge excluded, bottom edge included
            if (overlapsX(bus.posX, i) && bus.posY > PLATFORM_Y[i] &&
                bus.posY <= PLATFORM_Y[i] + TILE_SIZE)
                hitHead = 1'b1;
            // standing window, same tolerance for landing snap
            if (overlapsX(bus.posX, i) && feet >= PLATFORM_Y[i] &&
                feet <= PLATFORM_Y[i] + LAND_TOL) begin
                onPlatform = 1'b1;
                platTop    = PLATFORM_Y[i] - CHAR_HEIGHT;
            end
        end
    end

    assign onGround = feet >= GROUND_Y;

    assign bus.blockedLeft  = hitLeft;
    assign bus.blockedRight = hitRight;
    assign bus.headbutt     = hitHead;
    assign bus.supported    = onGround | onPlatform;
    // ground beats any platform
    assign bus.landY        = onGround ? GROUND_Y - CHAR_HEIGHT : platTop;

endmodule

/* rtl/platformerPkg.sv */
/*
 * Shared types and constants for the platformer core.
 * Coordinates follow a 640x480 scan with front porch offsets,
 * so the visible screen starts at x 143. The platform table is fixed.
 */
package platformerPkg;

    // scan and screen coordinates
    typedef logic [9:0] coordT;
    // vertical speed, negative means up
    typedef logic signed [6:0] velT;
    // 4 bits each of red, green, blue
    typedef logic [11:0] rgbT;

    typedef enum logic {
        GROUNDED,
        AIRBORNE
    } motionStateT;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////
    localparam coordT CHAR_WIDTH    = 10'd32;
    localparam coordT CHAR_HEIGHT   = 10'd32;
    localparam coordT SCREEN_LEFT   = 10'd143;
    localparam coordT SCREEN_RIGHT  = 10'd734 - CHAR_WIDTH;
    localparam coordT GROUND_Y      = 10'd460;
    localparam coordT GROUND_BOTTOM = 10'd516;
    localparam coordT START_X       = 10'd300;
    localparam coordT TILE_SIZE     = 10'd24;
    // feet may sink this far into a platform top
    localparam coordT LAND_TOL      = 10'd10;

    // platform top-left corners
    localparam int NUM_PLATFORMS = 4;
    localparam coordT PLATFORM_X [NUM_PLATFORMS] = '{10'd500, 10'd250, 10'd600, 10'd450};
    localparam coordT PLATFORM_Y [NUM_PLATFORMS] = '{10'd400, 10'd350, 10'd400, 10'd350};

    ////////////////////////////////////////
    // physics
    ////////////////////////////////////////
    localparam velT GRAVITY  = 7'sd1;
    localparam velT JUMP_VEL = 7'sd15;
    localparam int MOVE_DIV_DEFAULT = 500000;
    localparam int GRAV_DIV_DEFAULT = 1000000;

    // flat colours
    localparam rgbT BLACK          = 12'h000;
    localparam rgbT SKY_COLOR      = 12'h7AF;
    localparam rgbT GROUND_COLOR   = 12'h850;
    localparam rgbT PLATFORM_COLOR = 12'hF00;
    localparam rgbT PLAYER_COLOR   = 12'h0F0;

endpackage

/* rtl/platformerTop.sv */
/*
 * Platformer core top level. Scan timing comes from outside.
 * Buttons are plain levels, assumed already synchronised to clk.
 */
module platformerTop
    import platformerPkg::*;
#(
    parameter int MOVE_DIV = MOVE_DIV_DEFAULT,
    parameter int GRAV_DIV = GRAV_DIV_DEFAULT
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  bright,
    input  logic  btnLeft,
    input  logic  btnRight,
    input  logic  btnJump,
    input  coordT hCount,
    input  coordT vCount,
    output rgbT   rgb,
    output coordT playerX,
    output coordT playerY
);

    // position out, collision answers back
    collisionIf colBus ();

    platformMap map0 (
        .bus (colBus.map)
    );

    playerMotion #(
        .MOVE_DIV (MOVE_DIV),
        .GRAV_DIV (GRAV_DIV)
    ) motion0 (
        .clk      (clk),
        .rst      (rst),
        .btnLeft  (btnLeft),
        .btnRight (btnRight),
        .btnJump  (btnJump),
        .bus      (colBus.motion),
        .playerX  (playerX),
        .playerY  (playerY)
    );

    pixelRenderer render0 (
        .clk     (clk),
        .rst     (rst),
        .bright  (bright),
        .hCount  (hCount),
        .vCount  (vCount),
        .playerX (playerX),
        .playerY (playerY),
        .rgb     (rgb)
    );

endmodule

/* rtl/playerMotion.sv */
/*
 * Player position, vertical velocity and the grounded/airborne FSM.
 * MOVE_DIV and GRAV_DIV must be 2 or more. Left wins over right.
 * Vertical motion is only evaluated on physics ticks while airborne.
 */
module playerMotion
    import platformerPkg::*;
#(
    parameter int MOVE_DIV = MOVE_DIV_DEFAULT,
    parameter int GRAV_DIV = GRAV_DIV_DEFAULT
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         btnLeft,
    input  logic         btnRight,
    input  logic         btnJump,
    collisionIf.motion   bus,
    output coordT        playerX,
    output coordT        playerY
);

    typedef logic [$clog2(MOVE_DIV)-1:0] moveCntT;
    typedef logic [$clog2(GRAV_DIV)-1:0] gravCntT;

    moveCntT     moveCnt;
    gravCntT     gravCnt;
    logic        walking;
    logic        moveTick;
    logic        gravTick;
    coordT       posX;
    coordT       posY;
    velT         velY;
    motionStateT state;

    ////////////////////////////////////////
    // step dividers
    ////////////////////////////////////////
    assign walking  = btnLeft | btnRight;
    assign moveTick = walking && (moveCnt == moveCntT'(MOVE_DIV - 1));
    assign gravTick = gravCnt == gravCntT'(GRAV_DIV - 1);

    // walk divider idles at 0 while no direction held
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            moveCnt <= '0;
        end else if (!walking || moveTick) begin
            moveCnt <= '0;
        end else begin
            moveCnt <= moveCnt + 1'b1;
        end
    end

    // free running physics divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gravCnt <= '0;
        end else if (gravTick) begin
            gravCnt <= '0;
        end else begin
            gravCnt <= gravCnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // horizontal
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            posX <= START_X;
        end else if (moveTick) begin
            if (btnLeft) begin
                if (posX > SCREEN_LEFT && !bus.blockedLeft)
                    posX <= posX - 10'd1;
            end else if (posX < SCREEN_RIGHT && !bus.blockedRight) begin
                posX <= posX + 10'd1;
            end
        end
    end

    ////////////////////////////////////////
    // vertical FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= GROUNDED;
            posY  <= GROUND_Y - CHAR_HEIGHT;
            velY  <= '0;
        end else begin
            case (state)
                GROUNDED: begin
                    if (btnJump && bus.supported) begin
                        state <= AIRBORNE;
                        velY  <= -JUMP_VEL;
                    end else if (!bus.supported) begin
                        // walked off a ledge, start slow
                        state <= AIRBORNE;
                        velY  <= 7'sd1;
                    end
                end
                AIRBORNE: begin
                    if (gravTick) begin
                        if (velY < 0 && bus.headbutt) begin
                            velY <= '0;
                        end else if (velY > 0 && bus.supported) begin
                            // snap feet to the surface
                            posY  <= bus.landY;
                            velY  <= '0;
                            state <= GROUNDED;
                        end else begin
                            posY <= coordT'($signed({1'b0, posY}) + velY);
                            velY <= velY + GRAVITY;
                        end
                    end
                end
                default: state <= GROUNDED;
            endcase
        end
    end

    assign bus.posX = posX;
    assign bus.posY = posY;
    assign playerX  = posX;
    assign playerY  = posY;

endmodule

/* run.sh */
#!/bin/sh
# build and run the platformer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module platformerTb -f sources.f -Mdir obj_dir -o platformerSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/platformerSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

/* sources.f */
rtl/platformerPkg.sv
rtl/collisionIf.sv
rtl/platformMap.sv
rtl/playerMotion.sv
rtl/pixelRenderer.sv
rtl/platformerTop.sv
bench/platformer_checker.sv
bench/platformerTb.sv
